/* src.f */
+incdir+.
chiplet_types_pkg.sv
flit_counter.sv
rx_fsm.sv
rx_crc_check.sv
rx_msg_buffer.sv
rx_endpoint.sv
rx_endpoint_assertions.sv
tb_rx_endpoint.sv

/* Makefile */
VERILATOR ?= verilator
FILELIST  ?= src.f
TOP       ?= tb_rx_endpoint
RTL_TOP   ?= rx_endpoint
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only -Wall --timing
PASS_MSG  ?= sim passed
FAIL_MSG  ?= sim failed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# a run that ends without the pass line counts as a failure too
run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb_rx_endpoint.sv */
`timescale 1ns/1ps
`include "chiplet_defines.svh"

module tb_rx_endpoint import chiplet_types_pkg::*; ();

    localparam int CLK_PERIOD   = 100;
    localparam int DEPTH        = `RX_BUF_DEPTH;
    localparam int DONE_TIMEOUT = 8;
    localparam int READ_TIMEOUT = 16;
    localparam int RAND_PKTS    = 12;
    localparam int RAND_MAX_LEN = 16;
    // payload words and packets of the fixed tests
    localparam int FIXED_WORDS  = 161;
    localparam int FIXED_PKTS   = 9;
    localparam int WATCHDOG_CYCLES =
        (FIXED_WORDS + RAND_PKTS * RAND_MAX_LEN) * 4 + (FIXED_PKTS + RAND_PKTS) * 20 + 200;

    logic       clk;
    logic       n_rst;
    logic       flit_valid;
    flit_t      flit;
    logic       pkt_done;
    rx_status_t status;
    logic       rd_en;
    word_t      rd_data;
    logic       rd_valid;

    // unread committed words with the oldest at the front
    word_t scoreboard[$];
    string test_name;
    int    errors;
    int    checks;

    rx_endpoint rx_endpoint_inst (
        .clk        (clk),
        .n_rst      (n_rst),
        .flit_valid (flit_valid),
        .flit       (flit),
        .pkt_done   (pkt_done),
        .status     (status),
        .rd_en      (rd_en),
        .rd_data    (rd_data),
        .rd_valid   (rd_valid)
    );

    bind rx_endpoint rx_endpoint_assertions rx_endpoint_assertions_inst (
        .clk        (clk),
        .n_rst      (n_rst),
        .flit_valid (flit_valid),
        .hdr_accept (rx_fsm_inst.hdr_accept),
        .pkt_done   (pkt_done),
        .rd_valid   (rd_valid)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout after %0d cycles, the run stopped making progress", WATCHDOG_CYCLES);
        $display("sim failed");
        $finish;
    end

    // crc-16-ccitt shifted msb first over each word
    function automatic crc_t ref_crc(input word_t words[$]);
        crc_t crc;
        logic top;
        crc = 16'hFFFF;
        foreach (words[w]) begin
            for (int b = 31; b >= 0; b--) begin
                top = crc[15] ^ words[w][b];
                crc = {crc[14:0], 1'b0} ^ (top ? 16'h1021 : 16'h0000);
            end
        end
        return crc;
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("mismatch in %s, %s: expected %0h, actual %0h",
                     test_name, what, expected, actual);
        end
    endtask

    task automatic check_true(input logic cond, input string msg);
        checks++;
        assert (cond) else begin
            errors++;
            $display("%s: %s", test_name, msg);
        end
    endtask

    task automatic send_flit(input flit_t f);
        @(negedge clk);
        flit_valid = 1'b1;
        flit       = f;
    endtask

    task automatic drive_idle();
        @(negedge clk);
        flit_valid = 1'b0;
        flit       = '0;
    endtask

    // idles the link until the verdict pulse shows up
    task automatic wait_done(output logic seen, output rx_status_t seen_status);
        seen        = 1'b0;
        seen_status = '0;
        for (int i = 0; i < DONE_TIMEOUT && !seen; i++) begin
            drive_idle();
            if (pkt_done) begin
                seen        = 1'b1;
                seen_status = status;
            end
        end
    endtask

    task automatic run_packet(input int len, input crc_t flip, input logic exp_crc_ok,
                              input logic exp_overflow);
        word_t      words[$];
        crc_t       crc;
        logic       seen;
        rx_status_t got;
        rx_status_t exp_status;
        for (int i = 0; i < len; i++) begin
            words.push_back($urandom());
        end
        crc = ref_crc(words);
        send_flit({`MSG_FORMAT, 4'h2, pkt_length_t'(len), 16'h0000});
        // no flit right after a header
        drive_idle();
        foreach (words[i]) begin
            send_flit(words[i]);
        end
        // upper bits of the crc flit carry noise
        send_flit({16'($urandom()), crc ^ flip});
        wait_done(seen, got);
        exp_status.crc_ok   = exp_crc_ok;
        exp_status.overflow = exp_overflow;
        check_true(seen, $sformatf("no pkt_done for a packet of %0d words", len));
        if (seen) begin
            check_value("status", {30'b0, exp_status}, {30'b0, got});
        end
        if (exp_crc_ok && !exp_overflow) begin
            foreach (words[i]) begin
                scoreboard.push_back(words[i]);
            end
        end
    endtask

    // one pop per cycle while words are readable
    task automatic read_words(input int n);
        int    remaining;
        int    idle;
        word_t expected;
        remaining = n;
        idle      = 0;
        while (remaining > 0 && idle < READ_TIMEOUT) begin
            @(negedge clk);
            if (rd_valid && scoreboard.size() > 0) begin
                expected = scoreboard.pop_front();
                check_value("rd_data", expected, rd_data);
                rd_en     = 1'b1;
                remaining = remaining - 1;
                idle      = 0;
            end else begin
                rd_en = 1'b0;
                idle  = idle + 1;
            end
        end
        @(negedge clk);
        rd_en = 1'b0;
        check_true(remaining == 0, $sformatf("%0d words never became readable", remaining));
    endtask

    task automatic check_empty();
        repeat (2) @(negedge clk);
        check_value("rd_valid", 32'd0, 32'(rd_valid));
    endtask

    task automatic apply_reset();
        test_name = "reset";
        n_rst     = 1'b0;
        repeat (3) @(negedge clk);
        n_rst = 1'b1;
        check_value("pkt_done", 32'd0, 32'(pkt_done));
        check_value("rd_valid", 32'd0, 32'(rd_valid));
    endtask

    task automatic test_good_packet();
        test_name = "good_packet";
        run_packet(8, '0, 1'b1, 1'b0);
        read_words(8);
        check_empty();
    endtask

    task automatic test_bad_crc();
        crc_t flip;
        test_name = "bad_crc";
        flip      = crc_t'(1) << $urandom_range(0, `CRC_WIDTH - 1);
        run_packet(6, flip, 1'b0, 1'b0);
        check_empty();
        run_packet(5, '0, 1'b1, 1'b0);
        read_words(5);
        check_empty();
    endtask

    task automatic test_length_limits();
        test_name = "length_limits";
        run_packet(0, '0, 1'b1, 1'b0);
        check_empty();
        run_packet(DEPTH, '0, 1'b1, 1'b0);
        read_words(DEPTH);
        check_empty();
    endtask

    task automatic test_random_stream();
        int len;
        int free_words;
        test_name = "random_stream";
        for (int p = 0; p < RAND_PKTS; p++) begin
            len = $urandom_range(0, RAND_MAX_LEN);
            read_words($urandom_range(0, scoreboard.size()));
            // make room so the packet fits
            free_words = DEPTH - scoreboard.size();
            if (free_words < len) begin
                read_words(len - free_words);
            end
            run_packet(len, '0, 1'b1, 1'b0);
        end
        read_words(scoreboard.size());
        check_empty();
    endtask

    task automatic test_overflow();
        test_name = "overflow";
        run_packet(10, '0, 1'b1, 1'b0);
        // only DEPTH - 10 words fit behind the unread ones
        run_packet(60, '0, 1'b1, 1'b1);
        read_words(10);
        check_empty();
    endtask

    task automatic test_wrong_format();
        word_t      words[$];
        logic       seen;
        rx_status_t got;
        test_name = "wrong_format";
        // top nibble kept clear of the message format
        for (int i = 0; i < 4; i++) begin
            words.push_back({4'h0, 28'($urandom())});
        end
        // format 3 is not a message header
        send_flit({4'h3, 4'h2, 8'd4, 16'h0000});
        drive_idle();
        foreach (words[i]) begin
            send_flit(words[i]);
        end
        send_flit({16'h0000, ref_crc(words)});
        wait_done(seen, got);
        check_true(!seen, "pkt_done after a header with a wrong format");
        run_packet(4, '0, 1'b1, 1'b0);
        read_words(4);
        check_empty();
    endtask

    initial begin
        int assert_failures;
        flit_valid = 1'b0;
        flit       = '0;
        rd_en      = 1'b0;
        n_rst      = 1'b0;
        errors     = 0;
        checks     = 0;
        void'($urandom(72));
        apply_reset();
        test_good_packet();
        test_bad_crc();
        test_length_limits();
        test_random_stream();
        test_overflow();
        test_wrong_format();
        assert_failures = rx_endpoint_inst.rx_endpoint_assertions_inst.fail_count;
        $display("checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, assert_failures);
        if (errors == 0 && assert_failures == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* rx_endpoint_assertions.sv */
`timescale 1ns/1ps

module rx_endpoint_assertions (
    input logic clk,
    input logic n_rst,
    input logic flit_valid,
    input logic hdr_accept,
    input logic pkt_done,
    input logic rd_valid
);

    // number of failed assertions
    int fail_count = 0;

    // one verdict pulse per packet
    pkt_done_pulse: assert property (
        @(posedge clk) disable iff (!n_rst) pkt_done |=> !pkt_done
    ) else begin
        $error("pkt_done high for more than one cycle");
        fail_count++;
    end

    in_reset_quiet: assert property (
        @(posedge clk) !n_rst |-> (!rd_valid && !pkt_done)
    ) else begin
        $error("rd_valid or pkt_done high during reset");
        fail_count++;
    end

    after_reset_quiet: assert property (
        @(posedge clk) $rose(n_rst) |=> (!rd_valid && !pkt_done)
    ) else begin
        $error("rd_valid or pkt_done high right after reset");
        fail_count++;
    end

    // sender keeps the link idle while the length is decoded
    header_gap: assert property (
        @(posedge clk) disable iff (!n_rst) hdr_accept |=> !flit_valid
    ) else begin
        $error("flit_valid in the cycle after a header");
        fail_count++;
    end

endmodule

/* rx_endpoint.sv */
`timescale 1ns/1ps
`include "chiplet_defines.svh"

module rx_endpoint import chiplet_types_pkg::*; (
    input  logic       clk,
    input  logic       n_rst,
    input  logic       flit_valid,
    input  flit_t      flit,
    output logic       pkt_done,
    output rx_status_t status,
    input  logic       rd_en,
    output word_t      rd_data,
    output logic       rd_valid
);

    // counter control
    logic        cnt_clear;
    logic        cnt_enable;
    pkt_length_t cnt_terminal;
    logic        cnt_done;

    // crc path
    logic  crc_clear;
    logic  crc_word_en;
    word_t crc_word;
    crc_t  crc_final;
    logic  crc_ok;

    // buffer write side
    logic  buf_wr_en;
    word_t buf_wr_data;
    logic  buf_commit;
    logic  buf_drop;
    logic  buf_overflow;

    rx_fsm rx_fsm_inst (
        .clk          (clk),
        .n_rst        (n_rst),
        .flit_valid   (flit_valid),
        .flit         (flit),
        .cnt_clear    (cnt_clear),
        .cnt_enable   (cnt_enable),
        .cnt_terminal (cnt_terminal),
        .cnt_done     (cnt_done),
        .crc_clear    (crc_clear),
        .crc_word_en  (crc_word_en),
        .crc_word     (crc_word),
        .crc_final    (crc_final),
        .crc_ok       (crc_ok),
        .buf_wr_en    (buf_wr_en),
        .buf_wr_data  (buf_wr_data),
        .buf_commit   (buf_commit),
        .buf_drop     (buf_drop),
        .buf_overflow (buf_overflow),
        .pkt_done     (pkt_done),
        .status       (status)
    );

    // the running count itself is not needed outside the counter
    flit_counter flit_counter_inst (
        .clk           (clk),
        .n_rst         (n_rst),
        .clear         (cnt_clear),
        .count_enable  (cnt_enable),
        .terminal_val  (cnt_terminal),
        .count         (),
        .terminal_flag (cnt_done)
    );

    rx_crc_check rx_crc_check_inst (
        .clk      (clk),
        .n_rst    (n_rst),
        .clear    (crc_clear),
        .word_en  (crc_word_en),
        .word     (crc_word),
        .received (crc_final),
        .crc_ok   (crc_ok)
    );

    rx_msg_buffer #(
        .DEPTH (`RX_BUF_DEPTH)
    ) rx_msg_buffer_inst (
        .clk      (clk),
        .n_rst    (n_rst),
        .wr_en    (buf_wr_en),
        .wr_data  (buf_wr_data),
        .commit   (buf_commit),
        .drop     (buf_drop),
        .overflow (buf_overflow),
        .rd_en    (rd_en),
        .rd_data  (rd_data),
        .rd_valid (rd_valid)
    );

endmodule

/* rx_msg_buffer.sv */
`timescale 1ns/1ps
`include "chiplet_defines.svh"

module rx_msg_buffer import chiplet_types_pkg::*; #(
    parameter int DEPTH = `RX_BUF_DEPTH
) (
    input  logic  clk,
    input  logic  n_rst,
    input  logic  wr_en,
    input  word_t wr_data,
    input  logic  commit,
    input  logic  drop,
    output logic  overflow,
    input  logic  rd_en,
    output word_t rd_data,
    output logic  rd_valid
);

    localparam int ADDR_W = $clog2(DEPTH);

    // one extra bit tells full from empty
    typedef logic [ADDR_W:0] ptr_t;

    word_t mem [DEPTH];
    ptr_t  wr_ptr;
    ptr_t  cmt_ptr;
    ptr_t  rd_ptr;
    logic  full;
    logic  wr_ok;
    logic  rd_ok;

    // tentative words count against the space the reader has freed
    assign full = (ptr_t'(wr_ptr - rd_ptr) == ptr_t'(DEPTH));

    // once a packet overflows, the rest of it is discarded too
    assign wr_ok = wr_en && !full && !overflow;

    // only committed words are visible
    assign rd_valid = (rd_ptr != cmt_ptr);
    assign rd_ok    = rd_en && rd_valid;
    assign rd_data  = mem[rd_ptr[ADDR_W-1:0]];

    always_ff @(posedge clk) begin
        if (wr_ok) begin
            mem[wr_ptr[ADDR_W-1:0]] <= wr_data;
        end
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            wr_ptr   <= '0;
            cmt_ptr  <= '0;
            rd_ptr   <= '0;
            overflow <= 1'b0;
        end else begin
            // rewind discards the packet in flight
            if (drop) begin
                wr_ptr <= cmt_ptr;
            end else if (wr_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (commit) begin
                cmt_ptr <= wr_ptr;
            end
            // sticky until the packet is settled
            if (commit || drop) begin
                overflow <= 1'b0;
            end else if (wr_en && full) begin
                overflow <= 1'b1;
            end
            if (rd_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

/* rx_crc_check.sv */
`timescale 1ns/1ps
`include "chiplet_defines.svh"

module rx_crc_check import chiplet_types_pkg::*; (
    input  logic  clk,
    input  logic  n_rst,
    input  logic  clear,
    input  logic  word_en,
    input  word_t word,
    input  crc_t  received,
    output logic  crc_ok
);

    crc_t crc_q;

    // one serial shift per data bit, msb of the word first
    function automatic crc_t crc_update(input crc_t crc_in, input word_t data);
        crc_t c;
        logic fb;
        c = crc_in;
        for (int i = `FLIT_WIDTH - 1; i >= 0; i--) begin
            fb = c[`CRC_WIDTH-1] ^ data[i];
            c  = {c[`CRC_WIDTH-2:0], 1'b0};
            if (fb) begin
                c = c ^ `CRC_POLY;
            end
        end
        return c;
    endfunction

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            crc_q <= `CRC_INIT;
        end else if (clear) begin
            crc_q <= `CRC_INIT;
        end else if (word_en) begin
            crc_q <= crc_update(crc_q, word);
        end
    end

    // no payload leaves the register at its initial value
    assign crc_ok = (crc_q == received);

endmodule

/* rx_fsm.sv */
`timescale 1ns/1ps
`include "chiplet_defines.svh"

module rx_fsm import chiplet_types_pkg::*; (
    input  logic        clk,
    input  logic        n_rst,
    input  logic        flit_valid,
    input  flit_t       flit,
    output logic        cnt_clear,
    output logic        cnt_enable,
    output pkt_length_t cnt_terminal,
    input  logic        cnt_done,
    output logic        crc_clear,
    output logic        crc_word_en,
    output word_t       crc_word,
    output crc_t        crc_final,
    input  logic        crc_ok,
    output logic        buf_wr_en,
    output word_t       buf_wr_data,
    output logic        buf_commit,
    output logic        buf_drop,
    input  logic        buf_overflow,
    output logic        pkt_done,
    output rx_status_t  status
);

    rx_state_e state, next_state;
    pkt_hdr_t  hdr_in;
    pkt_hdr_t  hdr;
    logic      hdr_accept;
    logic      final_flit;

    assign hdr_in = pkt_hdr_t'(flit);

    // headers with a foreign format are ignored
    assign hdr_accept = (state == IDLE) && flit_valid && (hdr_in.format == `MSG_FORMAT);

    // the flit that completes the count is the crc flit
    assign final_flit = (state == RECV) && flit_valid && cnt_done;

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            state        <= IDLE;
            cnt_terminal <= '0;
        end else begin
            state <= next_state;
            if (state == GET_LENGTH) begin
                cnt_terminal <= expected_num_flits(hdr);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (hdr_accept) begin
            hdr <= hdr_in;
        end
        if (final_flit) begin
            crc_final <= flit[`CRC_WIDTH-1:0];
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (hdr_accept) begin
                    next_state = GET_LENGTH;
                end
            end
            GET_LENGTH: begin
                next_state = RECV;
            end
            RECV: begin
                if (final_flit) begin
                    next_state = CRC_CHECK;
                end
            end
            CRC_CHECK: begin
                next_state = IDLE;
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    // fresh crc and count for every packet
    assign cnt_clear = (state == GET_LENGTH);
    assign crc_clear = (state == GET_LENGTH);

    // payload words feed both the crc and the buffer
    assign cnt_enable  = (state == RECV) && flit_valid;
    assign crc_word_en = cnt_enable && !cnt_done;
    assign buf_wr_en   = crc_word_en;
    assign crc_word    = flit;
    assign buf_wr_data = flit;

    // verdict cycle, one after the crc flit
    assign pkt_done   = (state == CRC_CHECK);
    assign buf_commit = pkt_done && crc_ok && !buf_overflow;
    assign buf_drop   = pkt_done && !buf_commit;

    always_comb begin
        status = '0;
        if (pkt_done) begin
            status.crc_ok   = crc_ok;
            status.overflow = buf_overflow;
        end
    end

endmodule

/* flit_counter.sv */
`timescale 1ns/1ps
`include "chiplet_defines.svh"

module flit_counter import chiplet_types_pkg::*; (
    input  logic        clk,
    input  logic        n_rst,
    input  logic        clear,
    input  logic        count_enable,
    input  pkt_length_t terminal_val,
    output pkt_length_t count,
    output logic        terminal_flag
);

    pkt_length_t next_count;

    // wraps mod 2^width, so a terminal value of zero means a full lap
    assign next_count = pkt_length_t'(count + 1'b1);

    // flags the flit that will bring the count to terminal_val
    assign terminal_flag = (next_count == terminal_val);

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            count <= '0;
        end else if (clear) begin
            count <= '0;
        end else if (count_enable) begin
            count <= next_count;
        end
    end

endmodule

/* chiplet_types_pkg.sv */
`include "chiplet_defines.svh"

package chiplet_types_pkg;

    // one flit on the link and one word in the buffer
    typedef logic [`FLIT_WIDTH-1:0] flit_t;
    typedef logic [`FLIT_WIDTH-1:0] word_t;

    // flit or word count
    typedef logic [`PKT_LENGTH_WIDTH-1:0] pkt_length_t;

    typedef logic [`CRC_WIDTH-1:0] crc_t;

    // header flit layout, format in the top nibble
    typedef struct packed {
        logic [3:0]  format;
        logic [3:0]  dest_id;
        pkt_length_t length;
        logic [15:0] reserved;
    } pkt_hdr_t;

    // outcome reported with pkt_done
    typedef struct packed {
        logic crc_ok;
        logic overflow;
    } rx_status_t;

    typedef enum logic [1:0] {
        IDLE,
        GET_LENGTH,
        RECV,
        CRC_CHECK
    } rx_state_e;

    // payload words plus the trailing crc flit
    function automatic pkt_length_t expected_num_flits(input pkt_hdr_t hdr);
        return pkt_length_t'(hdr.length + 1'b1);
    endfunction

endpackage

/* chiplet_defines.svh */
`ifndef CHIPLET_DEFINES_SVH
`define CHIPLET_DEFINES_SVH

// link and packet geometry
`define FLIT_WIDTH       32
`define PKT_LENGTH_WIDTH 8
`define CRC_WIDTH        16

// words held by the receive message buffer
`define RX_BUF_DEPTH     64

// format code carried by a message header
`define MSG_FORMAT       4'h1

// crc-16-ccitt, msb first
`define CRC_POLY         16'h1021
`define CRC_INIT         16'hFFFF

`endif
